// ==== design/cache4way_pkg.sv ====
`default_nettype none

package cache4way_pkg;

    // associativity
    localparam int WAYS = 4;
    // enough to name any of the ways
    localparam int WAY_BIT = 2;

    // physical address seen by the cache
    localparam int ADDR_W = 32;

    // processor word and its byte enables
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // byte offset inside a word, never used for indexing
    localparam int BYTE_OFS_BIT = 2;

    // tree pseudo-LRU for four ways
    // bit 0 picks the half, bits 1 and 2 pick inside each half
    localparam int HIST_BIT = 3;

endpackage

`default_nettype wire

// ==== design/cache_way_store.sv ====
`default_nettype none

module cache_way_store
    import cache4way_pkg::*;
#(
    parameter int BLKIDX_BIT = 6,
    parameter int WRDIDX_BIT = 4,
    localparam int TAG_BIT = ADDR_W - BYTE_OFS_BIT - WRDIDX_BIT - BLKIDX_BIT
) (
    input  logic                  clk,
    input  logic                  rst,
    // processor lookup port
    input  logic [BLKIDX_BIT-1:0] lk_blkidx,
    input  logic [WRDIDX_BIT-1:0] lk_wrdidx,
    input  logic [STRB_W-1:0]     lk_wen,
    input  logic [DATA_W-1:0]     lk_wdata,
    output logic [DATA_W-1:0]     lk_rdata,
    output logic [TAG_BIT-1:0]    lk_tag,
    output logic                  lk_valid,
    output logic                  lk_dirty,
    // victim readout for writeback
    input  logic [WRDIDX_BIT-1:0] wb_wrdidx,
    output logic [DATA_W-1:0]     wb_rdata,
    // refill port
    input  logic                  fill_we,
    input  logic [BLKIDX_BIT-1:0] fill_blkidx,
    input  logic [WRDIDX_BIT-1:0] fill_wrdidx,
    input  logic [DATA_W-1:0]     fill_wdata,
    input  logic [TAG_BIT-1:0]    fill_tag,
    input  logic                  fill_done
);

    localparam int SETS  = 2 ** BLKIDX_BIT;
    localparam int LINES = SETS * (2 ** WRDIDX_BIT);

    // flat word store, addressed by {set, word}
    logic [DATA_W-1:0]  data_mem [LINES];
    logic [TAG_BIT-1:0] tag_mem  [SETS];
    logic [SETS-1:0]    valid;
    logic [SETS-1:0]    dirty;

    // lookup side, all combinational
    assign lk_rdata = data_mem[{lk_blkidx, lk_wrdidx}];
    assign lk_tag   = tag_mem[lk_blkidx];
    assign lk_valid = valid[lk_blkidx];
    assign lk_dirty = dirty[lk_blkidx];

    // writeback reads the set being refilled
    assign wb_rdata = data_mem[{fill_blkidx, wb_wrdidx}];

    // refill wins over a processor write
    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[{fill_blkidx, fill_wrdidx}] <= fill_wdata;
        end else begin
            for (int b = 0; b < STRB_W; b++) begin
                if (lk_wen[b]) begin
                    data_mem[{lk_blkidx, lk_wrdidx}][b*8 +: 8] <= lk_wdata[b*8 +: 8];
                end
            end
        end
    end

    // tag lands together with the last refill word
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_mem[fill_blkidx] <= fill_tag;
        end
    end

    // a fresh line is valid and clean
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill_done) begin
            valid[fill_blkidx] <= 1'b1;
            dirty[fill_blkidx] <= 1'b0;
        end else if (|lk_wen) begin
            dirty[lk_blkidx] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_plru.sv ====
`default_nettype none

module cache_plru
    import cache4way_pkg::*;
#(
    parameter int BLKIDX_BIT = 6
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [BLKIDX_BIT-1:0] blkidx,
    input  logic [WAYS-1:0]       valid,
    input  logic                  touch,
    input  logic [WAY_BIT-1:0]    touch_way,
    output logic [WAY_BIT-1:0]    victim
);

    localparam int SETS = 2 ** BLKIDX_BIT;

    logic [HIST_BIT-1:0] hist [SETS];
    logic [HIST_BIT-1:0] cur;
    logic [HIST_BIT-1:0] nxt;

    assign cur = hist[blkidx];

    // tree walk first, then any empty way overrides it
    always_comb begin
        victim = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
        // descending, so the lowest invalid way is the one kept
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid[w]) begin
                victim = WAY_BIT'(w);
            end
        end
    end

    // point every node on the path away from the touched way
    always_comb begin
        nxt    = cur;
        nxt[0] = ~touch_way[1];
        if (touch_way[1]) begin
            nxt[2] = ~touch_way[0];
        end else begin
            nxt[1] = ~touch_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                hist[s] <= '0;
            end
        end else if (touch) begin
            hist[blkidx] <= nxt;
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_lookup.sv ====
`default_nettype none

module cache_lookup
    import cache4way_pkg::*;
#(
    parameter int BLKIDX_BIT = 6,
    parameter int WRDIDX_BIT = 4,
    localparam int TAG_BIT = ADDR_W - BYTE_OFS_BIT - WRDIDX_BIT - BLKIDX_BIT
) (
    input  logic                     clk,
    input  logic                     rst,
    // processor request, held while stalled
    input  logic                     en,
    input  logic [ADDR_W-1:0]        paddr,
    input  logic [STRB_W-1:0]        wen,
    input  logic [DATA_W-1:0]        wdata,
    output logic [DATA_W-1:0]        rdata,
    output logic                     stall,
    // miss handler status
    input  logic                     busy,
    input  logic                     fin,
    // per-way lookup results, way 0 in the low slice
    input  logic [WAYS*TAG_BIT-1:0]  way_tag,
    input  logic [WAYS-1:0]          way_valid,
    input  logic [WAYS*DATA_W-1:0]   way_rdata,
    output logic [BLKIDX_BIT-1:0]    blkidx,
    output logic [WRDIDX_BIT-1:0]    wrdidx,
    output logic [WAYS*STRB_W-1:0]   way_wen,
    // history and miss start
    output logic                     touch,
    output logic [WAY_BIT-1:0]       touch_way,
    output logic                     miss_start,
    output logic [ADDR_W-1:0]        miss_paddr
);

    logic [TAG_BIT-1:0] tag;
    logic [WAYS-1:0]    hit_vec;
    logic               hit;
    logic [DATA_W-1:0]  hit_word;
    logic               done;
    logic               miss_sent;

    // address split: tag | set | word | byte
    assign tag    = paddr[ADDR_W-1 -: TAG_BIT];
    assign blkidx = paddr[BYTE_OFS_BIT+WRDIDX_BIT +: BLKIDX_BIT];
    assign wrdidx = paddr[BYTE_OFS_BIT +: WRDIDX_BIT];

    // one-hot hit, word and way of the hit
    always_comb begin
        hit_word  = '0;
        touch_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = way_valid[w] && (way_tag[w*TAG_BIT +: TAG_BIT] == tag);
            if (hit_vec[w]) begin
                hit_word  = hit_word | way_rdata[w*DATA_W +: DATA_W];
                touch_way = WAY_BIT'(w);
            end
        end
    end

    assign hit = |hit_vec;

    // rdata shows the word as it stands after this access
    always_comb begin
        rdata = hit_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (wen[b]) begin
                rdata[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    // stall rises in the request cycle of a miss
    assign stall = busy || (en && !hit);
    assign done  = en && !stall;

    // byte enables only reach the hit way
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_wen[w*STRB_W +: STRB_W] = (done && hit_vec[w]) ? wen : '0;
        end
    end

    // fin cycle already hits on the new line, so touch_way is right
    assign touch = done || fin;

    // one start per request
    assign miss_start = en && !hit && !busy && !miss_sent;
    assign miss_paddr = paddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            miss_sent <= 1'b0;
        end else if (done) begin
            miss_sent <= 1'b0;
        end else if (miss_start) begin
            miss_sent <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_miss_handler.sv ====
`default_nettype none

module cache_miss_handler
    import cache4way_pkg::*;
#(
    parameter int BLKIDX_BIT = 6,
    parameter int WRDIDX_BIT = 4,
    localparam int TAG_BIT = ADDR_W - BYTE_OFS_BIT - WRDIDX_BIT - BLKIDX_BIT
) (
    input  logic                  clk,
    input  logic                  rst,
    // from lookup
    input  logic                  miss_start,
    input  logic [ADDR_W-1:0]     miss_paddr,
    input  logic [WAY_BIT-1:0]    victim,
    // victim line, selected by fill_way
    input  logic [TAG_BIT-1:0]    victim_tag,
    input  logic                  victim_dirty,
    input  logic [DATA_W-1:0]     wb_rdata,
    output logic [WRDIDX_BIT-1:0] wb_wrdidx,
    output logic                  busy,
    output logic                  fin,
    output logic [WAY_BIT-1:0]    fill_way,
    // refill into the victim way
    output logic                  fill_we,
    output logic [BLKIDX_BIT-1:0] fill_blkidx,
    output logic [WRDIDX_BIT-1:0] fill_wrdidx,
    output logic [DATA_W-1:0]     fill_wdata,
    output logic [TAG_BIT-1:0]    fill_tag,
    output logic                  fill_done,
    // burst memory side
    output logic                  mem_rd,
    output logic                  mem_wr,
    output logic [ADDR_W-1:0]     mem_addr,
    output logic [DATA_W-1:0]     mem_wdata,
    input  logic                  mem_rvalid,
    input  logic [DATA_W-1:0]     mem_rdata
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_WB     = 3'd1;
    localparam logic [2:0] S_REQ    = 3'd2;
    localparam logic [2:0] S_REFILL = 3'd3;
    localparam logic [2:0] S_FIN    = 3'd4;

    logic [2:0]            state;
    logic [WRDIDX_BIT-1:0] cnt;
    logic                  last;
    logic [TAG_BIT-1:0]    req_tag_q;
    logic [BLKIDX_BIT-1:0] req_blkidx_q;
    logic [TAG_BIT-1:0]    wb_tag_q;
    logic [WAY_BIT-1:0]    victim_q;

    assign last = &cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (miss_start) begin
                        // clean victim skips straight to the read request
                        state <= victim_dirty ? S_WB : S_REQ;
                        cnt   <= '0;
                    end
                end
                S_WB: begin
                    // one word per cycle, no back-pressure
                    cnt <= cnt + 1'b1;
                    if (last) begin
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    state <= S_REFILL;
                end
                S_REFILL: begin
                    // words may arrive with gaps
                    if (mem_rvalid) begin
                        cnt <= cnt + 1'b1;
                        if (last) begin
                            state <= S_FIN;
                        end
                    end
                end
                S_FIN: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // capture the miss, processor holds paddr anyway
    always_ff @(posedge clk) begin
        if (state == S_IDLE && miss_start) begin
            req_tag_q    <= miss_paddr[ADDR_W-1 -: TAG_BIT];
            req_blkidx_q <= miss_paddr[BYTE_OFS_BIT+WRDIDX_BIT +: BLKIDX_BIT];
            wb_tag_q     <= victim_tag;
            victim_q     <= victim;
        end
    end

    assign busy = (state != S_IDLE);
    assign fin  = (state == S_FIN);

    // live victim while idle so dirty is seen in the request cycle
    assign fill_way = busy ? victim_q : victim;

    assign wb_wrdidx   = cnt;
    assign fill_we     = (state == S_REFILL) && mem_rvalid;
    assign fill_blkidx = req_blkidx_q;
    assign fill_wrdidx = cnt;
    assign fill_wdata  = mem_rdata;
    assign fill_tag    = req_tag_q;
    // tag and valid go in with the last word
    assign fill_done   = fill_we && last;

    assign mem_wr    = (state == S_WB);
    assign mem_rd    = (state == S_REQ);
    assign mem_wdata = wb_rdata;

    // writeback walks the old line; read asks for the new line base
    assign mem_addr = mem_wr ?
        {wb_tag_q, req_blkidx_q, cnt, {BYTE_OFS_BIT{1'b0}}} :
        {req_tag_q, req_blkidx_q, {WRDIDX_BIT{1'b0}}, {BYTE_OFS_BIT{1'b0}}};

endmodule

`default_nettype wire

// ==== design/cache4way.sv ====
`default_nettype none

module cache4way
    import cache4way_pkg::*;
#(
    parameter int BLKIDX_BIT = 6,
    parameter int WRDIDX_BIT = 4,
    localparam int TAG_BIT = ADDR_W - BYTE_OFS_BIT - WRDIDX_BIT - BLKIDX_BIT
) (
    input  logic              clk,
    input  logic              rst,
    // sram-like processor port
    input  logic              en,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [STRB_W-1:0] wen,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata,
    output logic              stall,
    // burst memory port
    output logic              mem_rd,
    output logic              mem_wr,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata,
    input  logic              mem_rvalid,
    input  logic [DATA_W-1:0] mem_rdata
);

    logic [BLKIDX_BIT-1:0]  blkidx;
    logic [WRDIDX_BIT-1:0]  wrdidx;
    logic [WAYS*STRB_W-1:0] way_wen;
    logic [WAYS*DATA_W-1:0] way_rdata;
    logic [WAYS*TAG_BIT-1:0] way_tag;
    logic [WAYS-1:0]        way_valid;
    logic [WAYS-1:0]        way_dirty;
    logic [WAYS*DATA_W-1:0] way_wb_rdata;
    logic [WAYS-1:0]        fill_sel;
    logic                   touch;
    logic [WAY_BIT-1:0]     touch_way;
    logic [WAY_BIT-1:0]     victim;
    logic                   miss_start;
    logic [ADDR_W-1:0]      miss_paddr;
    logic                   busy;
    logic                   fin;
    logic [WAY_BIT-1:0]     fill_way;
    logic [WRDIDX_BIT-1:0]  wb_wrdidx;
    logic [DATA_W-1:0]      wb_rdata;
    logic [TAG_BIT-1:0]     victim_tag;
    logic                   victim_dirty;
    logic                   fill_we;
    logic [BLKIDX_BIT-1:0]  fill_blkidx;
    logic [WRDIDX_BIT-1:0]  fill_wrdidx;
    logic [DATA_W-1:0]      fill_wdata;
    logic [TAG_BIT-1:0]     fill_tag;
    logic                   fill_done;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        assign fill_sel[w] = (fill_way == WAY_BIT'(w));

        cache_way_store #(
            .BLKIDX_BIT (BLKIDX_BIT),
            .WRDIDX_BIT (WRDIDX_BIT)
        ) u_way (
            .clk         (clk),
            .rst         (rst),
            .lk_blkidx   (blkidx),
            .lk_wrdidx   (wrdidx),
            .lk_wen      (way_wen[w*STRB_W +: STRB_W]),
            .lk_wdata    (wdata),
            .lk_rdata    (way_rdata[w*DATA_W +: DATA_W]),
            .lk_tag      (way_tag[w*TAG_BIT +: TAG_BIT]),
            .lk_valid    (way_valid[w]),
            .lk_dirty    (way_dirty[w]),
            .wb_wrdidx   (wb_wrdidx),
            .wb_rdata    (way_wb_rdata[w*DATA_W +: DATA_W]),
            .fill_we     (fill_we && fill_sel[w]),
            .fill_blkidx (fill_blkidx),
            .fill_wrdidx (fill_wrdidx),
            .fill_wdata  (fill_wdata),
            .fill_tag    (fill_tag),
            .fill_done   (fill_done && fill_sel[w])
        );
    end

    // victim view for the handler, lookup index equals the held miss index
    assign wb_rdata     = way_wb_rdata[fill_way*DATA_W +: DATA_W];
    assign victim_tag   = way_tag[fill_way*TAG_BIT +: TAG_BIT];
    assign victim_dirty = way_dirty[fill_way];

    cache_plru #(
        .BLKIDX_BIT (BLKIDX_BIT)
    ) u_plru (
        .clk       (clk),
        .rst       (rst),
        .blkidx    (blkidx),
        .valid     (way_valid),
        .touch     (touch),
        .touch_way (touch_way),
        .victim    (victim)
    );

    cache_lookup #(
        .BLKIDX_BIT (BLKIDX_BIT),
        .WRDIDX_BIT (WRDIDX_BIT)
    ) u_lookup (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .paddr      (paddr),
        .wen        (wen),
        .wdata      (wdata),
        .rdata      (rdata),
        .stall      (stall),
        .busy       (busy),
        .fin        (fin),
        .way_tag    (way_tag),
        .way_valid  (way_valid),
        .way_rdata  (way_rdata),
        .blkidx     (blkidx),
        .wrdidx     (wrdidx),
        .way_wen    (way_wen),
        .touch      (touch),
        .touch_way  (touch_way),
        .miss_start (miss_start),
        .miss_paddr (miss_paddr)
    );

    cache_miss_handler #(
        .BLKIDX_BIT (BLKIDX_BIT),
        .WRDIDX_BIT (WRDIDX_BIT)
    ) u_miss_handler (
        .clk          (clk),
        .rst          (rst),
        .miss_start   (miss_start),
        .miss_paddr   (miss_paddr),
        .victim       (victim),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .wb_rdata     (wb_rdata),
        .wb_wrdidx    (wb_wrdidx),
        .busy         (busy),
        .fin          (fin),
        .fill_way     (fill_way),
        .fill_we      (fill_we),
        .fill_blkidx  (fill_blkidx),
        .fill_wrdidx  (fill_wrdidx),
        .fill_wdata   (fill_wdata),
        .fill_tag     (fill_tag),
        .fill_done    (fill_done),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // free running, first rising edge half a period in
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== tb/cache4way_assertions.sv ====
`default_nettype none

module cache4way_assertions (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic busy,
    input logic mem_rd,
    input logic mem_wr
);
    timeunit 1ns;
    timeprecision 1ps;

    // number of failed assertions so far
    int fail_cnt;

    initial begin
        fail_cnt = 0;
    end

    // both ports quiet right after reset
    a_reset_quiet: assert property (
        @(posedge clk) $fell(rst) |-> !stall && !mem_rd && !mem_wr
    ) else begin
        $error("stall or a memory strobe active in the first cycle after reset");
        fail_cnt = fail_cnt + 1;
    end

    // line read only from inside a miss
    a_rd_busy: assert property (
        @(posedge clk) disable iff (rst) mem_rd |-> busy
    ) else begin
        $error("mem_rd strobe while the miss handler is idle");
        fail_cnt = fail_cnt + 1;
    end

    // writeback burst has no holes, the read request follows at once
    a_wr_burst: assert property (
        @(posedge clk) disable iff (rst) $fell(mem_wr) |-> mem_rd
    ) else begin
        $error("mem_wr burst broken or not followed by mem_rd");
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind cache4way cache4way_assertions u_assert (
    .clk    (clk),
    .rst    (rst),
    .stall  (stall),
    .busy   (busy),
    .mem_rd (mem_rd),
    .mem_wr (mem_wr)
);

`default_nettype wire

// ==== tb/cache4way_tb.sv ====
`default_nettype none

module cache4way_tb
    import cache4way_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BLKIDX_BIT = 6;
    localparam int WRDIDX_BIT = 4;
    localparam int TAG_BIT = ADDR_W - BYTE_OFS_BIT - WRDIDX_BIT - BLKIDX_BIT;
    localparam int SETS = 2 ** BLKIDX_BIT;
    localparam int WORDS = 2 ** WRDIDX_BIT;
    localparam int NUM_REQ = 400;
    // writeback, request, refill with a gap before every word, finish
    localparam int MISS_CYCLES = WORDS + 2 + 2 * WORDS + 4;
    localparam int TIMEOUT_NS = (16 + NUM_REQ * (MISS_CYCLES + 2)) * 10;
    // eight tags from here up share each set
    localparam int TAG_BASE = 'h2c0;

    logic              clk;
    logic              rst;
    logic              en;
    logic [ADDR_W-1:0] paddr;
    logic [STRB_W-1:0] wen;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              stall;
    logic              mem_rd;
    logic              mem_wr;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic              mem_rvalid;
    logic [DATA_W-1:0] mem_rdata;

    // backing memory, filled on first touch
    logic [DATA_W-1:0]   mem_words [logic [ADDR_W-1:0]];
    // reference cache state
    logic                m_valid [SETS][WAYS];
    logic                m_dirty [SETS][WAYS];
    logic [TAG_BIT-1:0]  m_tag   [SETS][WAYS];
    logic [DATA_W-1:0]   m_data  [SETS][WAYS][WORDS];
    logic [HIST_BIT-1:0] m_hist  [SETS];
    // memory traffic the model predicts, consumed by the memory side
    logic [ADDR_W-1:0]   exp_wr_addr [$];
    logic [DATA_W-1:0]   exp_wr_data [$];
    logic [ADDR_W-1:0]   exp_rd_addr [$];
    int                  wr_idx;
    int                  rd_idx;
    integer              seed;

    tb_clock_gen #(.PERIOD_NS(10)) u_clk (.clk(clk));

    cache4way #(
        .BLKIDX_BIT (BLKIDX_BIT),
        .WRDIDX_BIT (WRDIDX_BIT)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .paddr      (paddr),
        .wen        (wen),
        .wdata      (wdata),
        .rdata      (rdata),
        .stall      (stall),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s exp %h act %h", name, exp, act);
            fail_now($sformatf("%s differs from the reference model", name));
        end
    endtask

    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
        if (!mem_words.exists(a)) begin
            mem_words[a] = $random(seed);
        end
        return mem_words[a];
    endfunction

    function automatic logic [ADDR_W-1:0] word_addr(input logic [TAG_BIT-1:0] t,
                                                    input int s, input int w);
        return {t, BLKIDX_BIT'(s), WRDIDX_BIT'(w), {BYTE_OFS_BIT{1'b0}}};
    endfunction

    function automatic int pick_victim(input int s);
        // empty ways first, lowest number wins
        for (int w = 0; w < WAYS; w++) begin
            if (!m_valid[s][w]) begin
                return w;
            end
        end
        if (m_hist[s][0] == 1'b0) begin
            return m_hist[s][1] ? 1 : 0;
        end
        return m_hist[s][2] ? 3 : 2;
    endfunction

    // tree now points at the other half and at the sibling way
    task automatic touch_model(input int s, input int w);
        if (w < 2) begin
            m_hist[s][0] = 1'b1;
            m_hist[s][1] = (w == 0);
        end else begin
            m_hist[s][0] = 1'b0;
            m_hist[s][2] = (w == 2);
        end
    endtask

    task automatic model_access(input logic [ADDR_W-1:0] a, input logic [STRB_W-1:0] be,
                                input logic [DATA_W-1:0] d, output logic hit,
                                output logic [DATA_W-1:0] word);
        logic [TAG_BIT-1:0] t;
        int s;
        int w;
        int way;
        t = a[ADDR_W-1 -: TAG_BIT];
        s = int'(a[BYTE_OFS_BIT+WRDIDX_BIT +: BLKIDX_BIT]);
        w = int'(a[BYTE_OFS_BIT +: WRDIDX_BIT]);
        hit = 1'b0;
        way = 0;
        for (int i = 0; i < WAYS; i++) begin
            if (m_valid[s][i] && m_tag[s][i] == t) begin
                hit = 1'b1;
                way = i;
            end
        end
        if (!hit) begin
            way = pick_victim(s);
            // dirty victim goes back word by word before the refill
            if (m_valid[s][way] && m_dirty[s][way]) begin
                for (int i = 0; i < WORDS; i++) begin
                    exp_wr_addr.push_back(word_addr(m_tag[s][way], s, i));
                    exp_wr_data.push_back(m_data[s][way][i]);
                    mem_words[word_addr(m_tag[s][way], s, i)] = m_data[s][way][i];
                end
            end
            exp_rd_addr.push_back(word_addr(t, s, 0));
            for (int i = 0; i < WORDS; i++) begin
                m_data[s][way][i] = mem_word(word_addr(t, s, i));
            end
            m_tag[s][way] = t;
            m_valid[s][way] = 1'b1;
            m_dirty[s][way] = 1'b0;
        end
        // read returns the word with this request's bytes merged in
        word = m_data[s][way][w];
        for (int b = 0; b < STRB_W; b++) begin
            if (be[b]) begin
                word[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        m_data[s][way][w] = word;
        if (|be) begin
            m_dirty[s][way] = 1'b1;
        end
        touch_model(s, way);
    endtask

    task automatic do_request();
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        logic [STRB_W-1:0] be;
        logic [DATA_W-1:0] d;
        logic              exp_hit;
        logic [DATA_W-1:0] exp_word;
        int                s;
        int                t;
        r = $random(seed);
        s = int'(r[7:0]) % 3;
        t = int'(r[15:8]) % 8;
        // about half are reads
        be = r[16] ? r[20:17] : '0;
        d = $random(seed);
        a = word_addr(TAG_BIT'(TAG_BASE + t), s, int'(r[27:24]));
        model_access(a, be, d, exp_hit, exp_word);
        @(negedge clk);
        en = 1'b1;
        paddr = a;
        wen = be;
        wdata = d;
        #1;
        // a hit never stalls
        check_value("stall", DATA_W'(!exp_hit), DATA_W'(stall));
        while (stall) begin
            @(negedge clk);
            #1;
        end
        check_value("rdata", exp_word, rdata);
        if (wr_idx != exp_wr_addr.size()) begin
            fail_now("writeback burst missing words before the request completed");
        end
        if (rd_idx != exp_rd_addr.size()) begin
            fail_now("miss completed without a line read on the memory side");
        end
        if (UUT.u_assert.fail_cnt != 0) begin
            fail_now("a bound protocol assertion fired");
        end
        @(posedge clk);
    endtask

    // memory side, looks at the strobes mid cycle
    initial begin : memory_model
        logic [ADDR_W-1:0] base;
        mem_rvalid = 1'b0;
        mem_rdata = '0;
        wr_idx = 0;
        rd_idx = 0;
        forever begin
            @(negedge clk);
            mem_rvalid = 1'b0;
            if (mem_wr) begin
                if (wr_idx >= exp_wr_addr.size()) begin
                    fail_now("memory write without a dirty eviction");
                end else begin
                    check_value("mem_addr", exp_wr_addr[wr_idx], mem_addr);
                    check_value("mem_wdata", exp_wr_data[wr_idx], mem_wdata);
                    wr_idx++;
                end
            end
            if (mem_rd) begin
                if (rd_idx >= exp_rd_addr.size()) begin
                    fail_now("line read on a request the model calls a hit");
                end else begin
                    check_value("mem_addr", exp_rd_addr[rd_idx], mem_addr);
                    rd_idx++;
                end
                base = mem_addr;
                for (int i = 0; i < WORDS; i++) begin
                    @(negedge clk);
                    // word content decides an occasional one-cycle gap
                    if (mem_words[base + ADDR_W'(i * 4)][1:0] == 2'b00) begin
                        mem_rvalid = 1'b0;
                        @(negedge clk);
                    end
                    mem_rvalid = 1'b1;
                    mem_rdata = mem_words[base + ADDR_W'(i * 4)];
                end
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout, %0d requests did not finish in time", NUM_REQ);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        seed = 89624;
        rst = 1'b1;
        en = 1'b0;
        paddr = '0;
        wen = '0;
        wdata = '0;
        for (int s = 0; s < SETS; s++) begin
            m_hist[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w] = '0;
            end
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        for (int n = 0; n < NUM_REQ; n++) begin
            do_request();
            r = $random(seed);
            // now and then a cycle with no request
            if (r[2:0] == 3'd0) begin
                @(negedge clk);
                en = 1'b0;
                wen = '0;
            end
        end
        @(negedge clk);
        en = 1'b0;
        wen = '0;
        repeat (4) @(negedge clk);
        if (UUT.u_assert.fail_cnt == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            fail_now($sformatf("%0d protocol assertion failures", UUT.u_assert.fail_cnt));
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/cache4way_pkg.sv
design/cache_way_store.sv
design/cache_plru.sv
design/cache_lookup.sv
design/cache_miss_handler.sv
design/cache4way.sv
tb/tb_clock_gen.sv
tb/cache4way_assertions.sv
tb/cache4way_tb.sv

// ==== Makefile ====
TOP = cache4way_tb

.PHONY: sim clean

# build and run; success only when the pass line appears in the output
sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f all.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
